//--- src.f
common/video_pkg.sv
common/tmds_pkg.sv
design/display_timing.sv
design/bitmap_paint.sv
tmds/tmds_encoder.sv
design/hello_top.sv
verif/hello_assertions.sv
verif/hello_tb.sv

//--- verif/hello_tb.sv
// testbench for the hello world video top level
// small raster, reference pixel and TMDS model, compared every pixel clock

`timescale 1ns/1ps

module hello_tb;

    localparam int h_active   = 40;
    localparam int h_front    = 2;
    localparam int h_sync     = 4;
    localparam int h_back     = 4;
    localparam int v_active   = 22;
    localparam int v_front    = 1;
    localparam int v_sync     = 2;
    localparam int v_back     = 2;
    localparam int scale_log2 = 1;  // 2x2 pixels per bitmap cell
    localparam int h_total      = h_active + h_front + h_sync + h_back;  // 50
    localparam int v_total      = v_active + v_front + v_sync + v_back;  // 27
    localparam int frame_cycles = h_total * v_total;                     // 1350
    localparam int run_cycles   = 2 * frame_cycles + 10;
    localparam int timeout_cycles = 3000;  // run plus reset plus some margin
    localparam logic [9:0]  tok_00    = 10'b1101010100;
    localparam logic [23:0] paint_rgb = 24'hffcc00;  // yellow
    localparam logic [23:0] back_rgb  = 24'h113377;  // dark blue

    logic                 clk_pix;
    logic                 arst_n;
    tmds_pkg::tmds_word_t tmds_ch0;
    tmds_pkg::tmds_word_t tmds_ch1;
    tmds_pkg::tmds_word_t tmds_ch2;
    logic                 frame_start;

    int         mx;          // model scan position
    int         my;
    int         disp [3];    // model running disparity per channel
    int         checked;     // pixel clocks compared so far
    int         cycles;
    logic [29:0] exp_q1;     // {ch2,ch1,ch0} expected one clock later
    logic [29:0] exp_q2;     // expected now

    // '#' marks a lit cell, column 0 on the left
    string glyph [11] = '{
        "#.#.###.#...#....##.",
        "#.#.#...#...#...#.#.",
        "###.##..#...#...#.#.",
        "#.#.#...#...#...#.#.",
        "#.#.###.###.###.##..",
        "....................",
        "#.#..##.###.#...##..",
        "#.#.#.#.#.#.#...#.#.",
        "#.#.#.#.##..#...#.#.",
        "###.#.#.#.#.#...#.#.",
        "###.##..#.#.###.###."
    };

    hello_top #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back),
        .scale_log2(scale_log2)
    ) i_hello_top (
        .clk_pix, .arst_n, .tmds_ch0, .tmds_ch1, .tmds_ch2, .frame_start
    );

    always #50 clk_pix = ~clk_pix;  // 100 ns pixel clock

    function automatic logic glyph_on(input int col, input int row);
        if (col >= 20 || row >= 11)
            return 1'b0;  // outside the bitmap is background
        return glyph[row].getc(col) == "#";
    endfunction

    // DVI 1.0 channel model, updates disp[ch]
    function automatic logic [9:0] encode_lane(input int ch, input logic de,
                                               input logic [7:0] d, input logic [1:0] c);
        int         ones;
        int         diff;  // ones minus zeros in the low byte of q_m
        logic [8:0] q_m;
        logic [9:0] sym;
        if (!de) begin
            disp[ch] = 0;
            case (c)
                2'b00:   sym = tok_00;
                2'b01:   sym = 10'b0010101011;
                2'b10:   sym = 10'b0101010100;
                default: sym = 10'b1010101011;
            endcase
            return sym;
        end
        ones   = $countones(d);
        q_m[8] = !((ones > 4) || (ones == 4 && !d[0]));  // 1 means xor chain
        q_m[0] = d[0];
        for (int i = 1; i < 8; i++)
            q_m[i] = q_m[8] ? (q_m[i-1] ^ d[i]) : ~(q_m[i-1] ^ d[i]);
        diff = 2 * $countones(q_m[7:0]) - 8;
        if (disp[ch] == 0 || diff == 0) begin
            sym      = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp[ch] = q_m[8] ? disp[ch] + diff : disp[ch] - diff;
        end else if ((disp[ch] > 0 && diff > 0) || (disp[ch] < 0 && diff < 0)) begin
            sym      = {1'b1, q_m[8], ~q_m[7:0]};  // inverted
            disp[ch] = disp[ch] - diff + (q_m[8] ? 2 : 0);
        end else begin
            sym      = {1'b0, q_m};
            disp[ch] = disp[ch] + diff - (q_m[8] ? 0 : 2);
        end
        return sym;
    endfunction

    // expected {ch2,ch1,ch0} for scan position (x,y)
    function automatic logic [29:0] expect_symbols(input int x, input int y);
        logic        de;
        logic        hs;
        logic        vs;
        logic [23:0] rgb;
        de  = (x < h_active) && (y < v_active);
        hs  = (x >= h_active + h_front) && (x < h_active + h_front + h_sync);
        vs  = (y >= v_active + v_front) && (y < v_active + v_front + v_sync);
        rgb = 24'h000000;  // black in blanking
        if (de)
            rgb = glyph_on(x >> scale_log2, y >> scale_log2) ? paint_rgb : back_rgb;
        return {encode_lane(2, de, rgb[23:16], 2'b00),
                encode_lane(1, de, rgb[15:8], 2'b00),
                encode_lane(0, de, rgb[7:0], {vs, hs})};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // compare on the falling edge, outputs settled since the rising one
    always @(negedge clk_pix) begin
        if (arst_n && checked < run_cycles) begin
            check(tmds_ch0, exp_q2[9:0], "tmds_ch0");
            check(tmds_ch1, exp_q2[19:10], "tmds_ch1");
            check(tmds_ch2, exp_q2[29:20], "tmds_ch2");
            check(frame_start, (mx == 0 && my == 0), "frame_start");
            check(i_hello_top.i_hello_assertions.fail_cnt, 0, "assertion failures");
            exp_q2 = exp_q1;  // two clock latency through painter and encoder
            exp_q1 = expect_symbols(mx, my);
            mx++;
            if (mx == h_total) begin
                mx = 0;
                my = (my == v_total - 1) ? 0 : my + 1;
            end
            checked++;
        end
    end

    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Testbench failed");
            $fatal(1, "run stopped by the timeout");
        end
    end

    initial begin
        clk_pix = 1'b0;
        arst_n  = 1'b0;
        mx      = 0;
        my      = 0;
        disp    = '{0, 0, 0};
        checked = 0;
        cycles  = 0;
        exp_q1  = {3{tok_00}};  // pipeline leaves reset in blanking
        exp_q2  = {3{tok_00}};
        repeat (3) @(posedge clk_pix);
        arst_n <= 1'b1;
        wait (checked == run_cycles);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- verif/hello_assertions.sv
// raster and TMDS symbol assertions, bound into the video top level
// sync against data enable, blanking range, control tokens in blanking

`timescale 1ns/1ps

module hello_assertions #(
    parameter int h_active = 1280
) (
    input logic                 clk_pix,
    input logic                 arst_n,
    input video_pkg::raster_t   raster,    // timing controller output
    input video_pkg::raster_t   raster_q,  // painter output, one stage later
    input tmds_pkg::tmds_word_t tmds_ch0,
    input tmds_pkg::tmds_word_t tmds_ch1,
    input tmds_pkg::tmds_word_t tmds_ch2
);

    int unsigned fail_cnt = 0;  // read by the testbench

    // the four DVI control codes
    function automatic logic is_token(input logic [9:0] s);
        return (s == 10'b1101010100) || (s == 10'b0010101011) ||
               (s == 10'b0101010100) || (s == 10'b1010101011);
    endfunction

    // hsync only starts inside blanking
    hsync_in_blank: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $rose(raster.hsync) |-> !raster.de)
        else begin
            fail_cnt++;
            $error("hsync rose while de was high");
        end

    de_in_active: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (raster.sx >= video_pkg::coord_t'(h_active)) |-> !raster.de)
        else begin
            fail_cnt++;
            $error("de high beyond the active width");
        end

    // symbol shows up one clock after raster_q
    token_in_blank: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !raster_q.de |=> (is_token(tmds_ch0) && is_token(tmds_ch1) && is_token(tmds_ch2)))
        else begin
            fail_cnt++;
            $error("data symbol sent during blanking");
        end

endmodule

bind hello_top hello_assertions #(.h_active(h_active)) i_hello_assertions (
    .clk_pix(clk_pix), .arst_n(arst_n), .raster(raster), .raster_q(raster_q),
    .tmds_ch0(tmds_ch0), .tmds_ch1(tmds_ch1), .tmds_ch2(tmds_ch2)
);

//--- design/hello_top.sv
// hello world video top level
// timing controller, bitmap painter and three TMDS encoders (blue, green, red)

`timescale 1ns/1ps

module hello_top #(
    parameter int h_active   = 1280,  // 720p defaults
    parameter int h_front    = 110,
    parameter int h_sync     = 40,
    parameter int h_back     = 220,
    parameter int v_active   = 720,
    parameter int v_front    = 5,
    parameter int v_sync     = 5,
    parameter int v_back     = 20,
    parameter int scale_log2 = 6
) (
    input  logic                 clk_pix,
    input  logic                 arst_n,
    output tmds_pkg::tmds_word_t tmds_ch0,    // blue plus syncs
    output tmds_pkg::tmds_word_t tmds_ch1,    // green
    output tmds_pkg::tmds_word_t tmds_ch2,    // red
    output logic                 frame_start  // frame alignment strobe
);

    video_pkg::raster_t raster;    // scan position, stage 0
    video_pkg::raster_t raster_q;  // aligned with pixel, stage 1
    video_pkg::pixel_t  pixel;

    display_timing #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) i_display_timing (
        .clk_pix, .arst_n, .raster, .frame_start
    );

    bitmap_paint #(.scale_log2(scale_log2)) i_bitmap_paint (
        .clk_pix, .arst_n, .raster, .pixel, .raster_q
    );

    tmds_encoder i_tmds_ch0 (
        .clk_pix, .arst_n, .data(pixel.b), .ctrl({raster_q.vsync, raster_q.hsync}),
        .de(raster_q.de), .symbol(tmds_ch0)
    );

    tmds_encoder i_tmds_ch1 (
        .clk_pix, .arst_n, .data(pixel.g), .ctrl(2'b00), .de(raster_q.de), .symbol(tmds_ch1)
    );

    tmds_encoder i_tmds_ch2 (
        .clk_pix, .arst_n, .data(pixel.r), .ctrl(2'b00), .de(raster_q.de), .symbol(tmds_ch2)
    );

endmodule

//--- tmds/tmds_encoder.sv
// DVI TMDS encoder for one channel
// 8b/10b transition minimizing with DC balance, control tokens in blanking

`timescale 1ns/1ps

module tmds_encoder (
    input  logic                clk_pix,
    input  logic                arst_n,
    input  logic [7:0]          data,    // colour lane
    input  logic [1:0]          ctrl,    // {c1,c0} for blanking
    input  logic                de,      // high sends data, low sends ctrl
    output tmds_pkg::tmds_word_t symbol  // registered 10-bit symbol
);

    logic [3:0]           n1_d;      // ones in data
    logic                 use_xnor;  // xnor chain gives fewer transitions
    logic [8:0]           q_m;       // transition minimized word
    logic [3:0]           n1_q;      // ones in q_m[7:0]
    tmds_pkg::disparity_t bal;       // ones minus zeros in q_m[7:0]
    tmds_pkg::disparity_t cnt;       // running disparity
    tmds_pkg::disparity_t cnt_next;
    tmds_pkg::tmds_word_t word;      // encoded data symbol

    // stage 1: minimize transitions
    always_comb begin
        n1_d = '0;
        for (int i = 0; i < 8; i++) n1_d = n1_d + 4'(data[i]);
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data[0]);
        q_m[0]   = data[0];
        for (int i = 1; i < 8; i++)
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        q_m[8] = ~use_xnor;  // 1 marks xor chaining
    end

    // stage 2: balance dc, maybe invert the low byte
    always_comb begin
        n1_q = '0;
        for (int i = 0; i < 8; i++) n1_q = n1_q + 4'(q_m[i]);
        bal = tmds_pkg::disparity_t'({n1_q, 1'b0} - 5'd8);  // 2*n1 - 8
        if (cnt == 0 || bal == 0) begin
            word     = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            cnt_next = q_m[8] ? cnt + bal : cnt - bal;
        end else if ((cnt > 0 && bal > 0) || (cnt < 0 && bal < 0)) begin
            word     = {1'b1, q_m[8], ~q_m[7:0]};  // invert to pull bias back
            cnt_next = cnt - bal + (q_m[8] ? 5'sd2 : 5'sd0);
        end else begin
            word     = {1'b0, q_m[8], q_m[7:0]};
            cnt_next = cnt + bal - (q_m[8] ? 5'sd0 : 5'sd2);
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            symbol <= tmds_pkg::ctrl_symbol(tmds_pkg::ctrl_00);
            cnt    <= '0;
        end else if (de) begin
            symbol <= word;
            cnt    <= cnt_next;
        end else begin
            symbol <= tmds_pkg::ctrl_symbol(tmds_pkg::tmds_ctrl_e'(ctrl));
            cnt    <= '0;  // bias restarts every blanking interval
        end
    end

endmodule

//--- design/bitmap_paint.sv
// bitmap painter
// looks up the scaled scan position in a 20x11 bitmap and picks the colour

`timescale 1ns/1ps

module bitmap_paint #(
    parameter int scale_log2 = 6  // each bitmap cell is 2**scale_log2 pixels square
) (
    input  logic               clk_pix,
    input  logic               arst_n,
    input  video_pkg::raster_t raster,
    output video_pkg::pixel_t  pixel,    // colour for raster_q
    output video_pkg::raster_t raster_q  // raster delayed to line up with pixel
);

    localparam int bmap_w = 20;  // columns
    localparam int bmap_h = 11;  // rows

    // msb first so column 0 is the leftmost pixel
    localparam logic [0:bmap_w-1] bmap [bmap_h] = '{
        20'b1010_1110_1000_1000_0110,  // h e l l o
        20'b1010_1000_1000_1000_1010,
        20'b1110_1100_1000_1000_1010,
        20'b1010_1000_1000_1000_1010,
        20'b1010_1110_1110_1110_1100,
        20'b0000_0000_0000_0000_0000,  // gap between words
        20'b1010_0110_1110_1000_1100,  // w o r l d
        20'b1010_1010_1010_1000_1010,
        20'b1010_1010_1100_1000_1010,
        20'b1110_1010_1010_1000_1010,
        20'b1110_1100_1010_1110_1110
    };

    video_pkg::coord_t col;     // bitmap column of this pixel
    video_pkg::coord_t row;     // bitmap row of this pixel
    logic              in_map;  // position lands inside the bitmap
    logic              set;     // bitmap bit is on

    always_comb begin
        col    = raster.sx >> scale_log2;
        row    = raster.sy >> scale_log2;
        in_map = (col < video_pkg::coord_t'(bmap_w)) && (row < video_pkg::coord_t'(bmap_h));
        set    = 1'b0;
        if (in_map) set = bmap[row[3:0]][col[4:0]];  // 11 rows fit 4 bits, 20 cols fit 5
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pixel    <= '0;  // black
            raster_q <= '0;  // blanking, syncs low
        end else begin
            raster_q <= raster;
            if (!raster.de)
                pixel <= '0;  // black outside the active area
            else if (set)
                pixel <= video_pkg::paint_colour;
            else
                pixel <= video_pkg::back_colour;
        end
    end

endmodule

//--- design/display_timing.sv
// display timing controller
// scans the screen, tracks line and frame phases, drives position and syncs

`timescale 1ns/1ps

module display_timing #(
    parameter int h_active = 1280,
    parameter int h_front  = 110,
    parameter int h_sync   = 40,
    parameter int h_back   = 220,
    parameter int v_active = 720,
    parameter int v_front  = 5,
    parameter int v_sync   = 5,
    parameter int v_back   = 20
) (
    input  logic                clk_pix,
    input  logic                arst_n,
    output video_pkg::raster_t  raster,      // registered scan state
    output logic                frame_start  // high at (0,0)
);

    // last position of each phase
    localparam video_pkg::coord_t h_end_act  = video_pkg::coord_t'(h_active - 1);
    localparam video_pkg::coord_t h_end_fp   = video_pkg::coord_t'(h_active + h_front - 1);
    localparam video_pkg::coord_t h_end_sync =
        video_pkg::coord_t'(h_active + h_front + h_sync - 1);
    localparam video_pkg::coord_t h_end_all  =
        video_pkg::coord_t'(h_active + h_front + h_sync + h_back - 1);
    localparam video_pkg::coord_t v_end_act  = video_pkg::coord_t'(v_active - 1);
    localparam video_pkg::coord_t v_end_fp   = video_pkg::coord_t'(v_active + v_front - 1);
    localparam video_pkg::coord_t v_end_sync =
        video_pkg::coord_t'(v_active + v_front + v_sync - 1);
    localparam video_pkg::coord_t v_end_all  =
        video_pkg::coord_t'(v_active + v_front + v_sync + v_back - 1);

    video_pkg::line_phase_e h_phase, h_phase_next;  // horizontal phase
    video_pkg::line_phase_e v_phase, v_phase_next;  // vertical phase
    video_pkg::coord_t      sx_next, sy_next;
    logic                   h_end;  // last pixel of the line
    logic                   v_end;  // last line of the frame

    // step one phase forward when pos hits the end of the current one
    function automatic video_pkg::line_phase_e next_phase(
        input video_pkg::line_phase_e ph,
        input video_pkg::coord_t      pos,
        input video_pkg::coord_t      end_act,
        input video_pkg::coord_t      end_fp,
        input video_pkg::coord_t      end_sync,
        input video_pkg::coord_t      end_all
    );
        video_pkg::line_phase_e nxt;
        nxt = ph;
        case (ph)
            video_pkg::phase_active: if (pos == end_act)  nxt = video_pkg::phase_front;
            video_pkg::phase_front:  if (pos == end_fp)   nxt = video_pkg::phase_sync;
            video_pkg::phase_sync:   if (pos == end_sync) nxt = video_pkg::phase_back;
            default:                 if (pos == end_all)  nxt = video_pkg::phase_active;
        endcase
        return nxt;
    endfunction

    always_comb begin
        h_end   = (raster.sx == h_end_all);
        v_end   = (raster.sy == v_end_all);
        sx_next = h_end ? '0 : raster.sx + 1'b1;
        sy_next = raster.sy;
        if (h_end) sy_next = v_end ? '0 : raster.sy + 1'b1;  // wrap after last line
        h_phase_next = next_phase(h_phase, raster.sx, h_end_act, h_end_fp, h_end_sync,
                                  h_end_all);
        // vertical phase only moves at the end of a line
        v_phase_next = h_end ? next_phase(v_phase, raster.sy, v_end_act, v_end_fp,
                                          v_end_sync, v_end_all) : v_phase;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            raster  <= '{sx: '0, sy: '0, hsync: 1'b0, vsync: 1'b0, de: 1'b1};  // (0,0) is active
            h_phase <= video_pkg::phase_active;
            v_phase <= video_pkg::phase_active;
        end else begin
            raster.sx    <= sx_next;
            raster.sy    <= sy_next;
            raster.hsync <= (h_phase_next == video_pkg::phase_sync);
            raster.vsync <= (v_phase_next == video_pkg::phase_sync);
            raster.de    <= (h_phase_next == video_pkg::phase_active) &&
                            (v_phase_next == video_pkg::phase_active);
            h_phase      <= h_phase_next;
            v_phase      <= v_phase_next;
        end
    end

    assign frame_start = (raster.sx == '0) && (raster.sy == '0);  // first pixel of frame

endmodule

//--- common/tmds_pkg.sv
// TMDS definitions for the DVI encoders
// symbol width, control tokens and running disparity

package tmds_pkg;

    typedef logic [9:0] tmds_word_t;  // one 10-bit symbol

    // control pair {c1,c0} sent during blanking
    typedef enum logic [1:0] {
        ctrl_00 = 2'b00,
        ctrl_01 = 2'b01,
        ctrl_10 = 2'b10,
        ctrl_11 = 2'b11
    } tmds_ctrl_e;

    typedef logic signed [4:0] disparity_t;  // running DC bias, always even

    // DVI 1.0 control token for a control pair
    function automatic tmds_word_t ctrl_symbol(input tmds_ctrl_e c);
        tmds_word_t sym;
        case (c)
            ctrl_00: sym = 10'b1101010100;
            ctrl_01: sym = 10'b0010101011;
            ctrl_10: sym = 10'b0101010100;
            default: sym = 10'b1010101011;  // ctrl_11
        endcase
        return sym;
    endfunction

endpackage

//--- common/video_pkg.sv
// video types shared by the timing controller and the painter
// raster position and sync bundle, pixel colour and line phase

package video_pkg;

    typedef logic [11:0] coord_t;  // unsigned screen coordinate

    // one scan position with its syncs, travels down the pipeline
    typedef struct packed {
        coord_t sx;     // horizontal position
        coord_t sy;     // vertical position
        logic   hsync;  // active high
        logic   vsync;  // active high
        logic   de;     // data enable, high in the active area
    } raster_t;

    // 24-bit colour, one byte per lane
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // where a counter sits within its line or frame
    typedef enum logic [1:0] {
        phase_active = 2'd0,
        phase_front  = 2'd1,
        phase_sync   = 2'd2,
        phase_back   = 2'd3
    } line_phase_e;

    // yellow strokes on dark blue, each nibble doubled into a byte
    localparam pixel_t paint_colour = '{r: 8'hff, g: 8'hcc, b: 8'h00};
    localparam pixel_t back_colour  = '{r: 8'h11, g: 8'h33, b: 8'h77};

endpackage
